//--- hdl/conv_accel_consts.svh
`ifndef CONV_ACCEL_CONSTS_SVH
`define CONV_ACCEL_CONSTS_SVH

// buffer geometry
`define CONV_DEPTH      16
`define CONV_IDX_W      4
`define CONV_WORD_W     32

// custom-0 major opcode
`define CONV_OPCODE     7'b0001011

// funct3 command codes
`define CONV_F3_LD_FILT  3'd0
`define CONV_F3_LD_DATA  3'd1
`define CONV_F3_CLR_FILT 3'd2
`define CONV_F3_CLR_DATA 3'd3
`define CONV_F3_RUN      3'd4

// funct7 bit position that asks for rs2 as a second word
`define CONV_F7_PAIR    0

`endif

//--- hdl/conv_accel_pkg.sv
`include "conv_accel_consts.svh"

package conv_accel_pkg;

    // command kind decoded from funct3
    typedef enum logic [2:0] {
        OP_NONE     = 3'd0,
        OP_LD_FILT  = 3'd1,
        OP_LD_DATA  = 3'd2,
        OP_CLR_FILT = 3'd3,
        OP_CLR_DATA = 3'd4,
        OP_RUN      = 3'd5
    } conv_op_e;

    // registered command from the decoder
    typedef struct packed {
        conv_op_e                op;
        logic                    pair;   // word1 is valid too
        logic [`CONV_WORD_W-1:0] word0;  // rs1
        logic [`CONV_WORD_W-1:0] word1;  // rs2
    } conv_cmd_t;

    // write request into one operand buffer
    typedef struct packed {
        logic                    we;
        logic                    pair;
        logic [`CONV_WORD_W-1:0] word0;
        logic [`CONV_WORD_W-1:0] word1;
    } buf_wr_t;

    // accumulator report towards writeback
    typedef struct packed {
        logic [`CONV_WORD_W-1:0] acc;
        logic                    busy;   // a present pair is still waiting
        logic                    flush;  // clear seen this cycle
    } conv_status_t;

endpackage

//--- hdl/conv_decoder.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module conv_decoder (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       enable_i,
    input  logic                       instr_valid_i,
    input  logic [31:0]                instr_i,
    input  logic [`CONV_WORD_W-1:0]    rs1_i,
    input  logic [`CONV_WORD_W-1:0]    rs2_i,
    output conv_accel_pkg::conv_cmd_t  cmd_o
);
    import conv_accel_pkg::*;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic                    accept;
    logic                    is_load;
    conv_op_e                op_dec;
    conv_op_e                op_q;
    logic                    pair_q;
    logic [`CONV_WORD_W-1:0] word0_q;
    logic [`CONV_WORD_W-1:0] word1_q;

    // R-type fields
    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign accept = instr_valid_i && enable_i && (opcode == `CONV_OPCODE);

    always_comb begin
        case (funct3)
            `CONV_F3_LD_FILT:  op_dec = OP_LD_FILT;
            `CONV_F3_LD_DATA:  op_dec = OP_LD_DATA;
            `CONV_F3_CLR_FILT: op_dec = OP_CLR_FILT;
            `CONV_F3_CLR_DATA: op_dec = OP_CLR_DATA;
            `CONV_F3_RUN:      op_dec = OP_RUN;
            default:           op_dec = OP_NONE; // reserved codes do nothing
        endcase
    end

    assign is_load = (op_dec == OP_LD_FILT) || (op_dec == OP_LD_DATA);

    // command lives for one cycle only
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_q   <= OP_NONE;
            pair_q <= 1'b0;
        end else begin
            op_q   <= accept ? op_dec : OP_NONE;
            pair_q <= accept && is_load && funct7[`CONV_F7_PAIR];
        end
    end

    always_ff @(posedge clk_i) begin
        word0_q <= rs1_i;
        word1_q <= rs2_i;
    end

    assign cmd_o = '{op: op_q, pair: pair_q, word0: word0_q, word1: word1_q};

    // only loads may carry a second word
    a_pair_on_load: assert property (@(posedge clk_i) disable iff (rst_i)
        cmd_o.pair |-> (cmd_o.op == OP_LD_FILT || cmd_o.op == OP_LD_DATA));

endmodule

//--- hdl/operand_buffer.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module operand_buffer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  conv_accel_pkg::buf_wr_t   wr_i,
    input  logic                      clear_i,
    input  logic [`CONV_IDX_W-1:0]    rd_idx_i,
    output logic [`CONV_WORD_W-1:0]   rd_word_o,
    output logic [`CONV_DEPTH-1:0]    present_o
);
    localparam int unsigned FILL_W = `CONV_IDX_W + 1;

    logic [`CONV_WORD_W-1:0] mem_q [`CONV_DEPTH];
    logic [`CONV_DEPTH-1:0]  present_q;
    logic [FILL_W-1:0]       fill_q;   // next free slot, 16 means full
    logic [`CONV_IDX_W-1:0]  idx0;
    logic [`CONV_IDX_W-1:0]  idx1;
    logic                    wr_first;
    logic                    wr_second;

    assign idx0 = fill_q[`CONV_IDX_W-1:0];
    assign idx1 = idx0 + 1'b1;

    // words that do not fit are dropped
    assign wr_first  = wr_i.we && (fill_q < FILL_W'(`CONV_DEPTH));
    assign wr_second = wr_i.we && wr_i.pair && (fill_q < FILL_W'(`CONV_DEPTH - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fill_q    <= '0;
            present_q <= '0;
        end else if (clear_i) begin
            fill_q    <= '0;
            present_q <= '0;
        end else begin
            fill_q <= fill_q + FILL_W'(wr_first) + FILL_W'(wr_second);
            if (wr_first)
                present_q[idx0] <= 1'b1;
            if (wr_second)
                present_q[idx1] <= 1'b1;
        end
    end

    // payload storage, gated by the present bits
    always_ff @(posedge clk_i) begin
        if (wr_first)
            mem_q[idx0] <= wr_i.word0;
        if (wr_second)
            mem_q[idx1] <= wr_i.word1;
    end

    assign rd_word_o = mem_q[rd_idx_i];
    assign present_o = present_q;

    // a write into a full buffer leaves it untouched
    a_full_drop: assert property (@(posedge clk_i) disable iff (rst_i)
        (wr_i.we && !clear_i && fill_q == FILL_W'(`CONV_DEPTH))
        |=> ($stable(present_q) && fill_q == FILL_W'(`CONV_DEPTH)));

endmodule

//--- hdl/conv_mac.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module conv_mac (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          enable_i,
    input  conv_accel_pkg::conv_cmd_t     cmd_i,
    output conv_accel_pkg::conv_status_t  status_o,
    output logic                          run_o
);
    import conv_accel_pkg::*;

    localparam int unsigned WALK_W = `CONV_IDX_W + 1;

    buf_wr_t                 filt_wr;
    buf_wr_t                 data_wr;
    logic                    clr_filt;
    logic                    clr_data;
    logic                    flush;
    logic [`CONV_DEPTH-1:0]  filt_present;
    logic [`CONV_DEPTH-1:0]  data_present;
    logic [`CONV_WORD_W-1:0] filt_word;
    logic [`CONV_WORD_W-1:0] data_word;
    logic [WALK_W-1:0]       walk_q;
    logic [`CONV_WORD_W-1:0] acc_q;
    logic [`CONV_IDX_W-1:0]  rd_idx;
    logic                    walk_end;
    logic                    pair_ready;

    // command to buffer traffic
    assign filt_wr = '{we: (cmd_i.op == OP_LD_FILT), pair: cmd_i.pair,
                       word0: cmd_i.word0, word1: cmd_i.word1};
    assign data_wr = '{we: (cmd_i.op == OP_LD_DATA), pair: cmd_i.pair,
                       word0: cmd_i.word0, word1: cmd_i.word1};
    assign clr_filt = (cmd_i.op == OP_CLR_FILT);
    assign clr_data = (cmd_i.op == OP_CLR_DATA);
    assign flush    = clr_filt || clr_data;
    assign run_o    = (cmd_i.op == OP_RUN);

    operand_buffer u_filter_buf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (filt_wr),
        .clear_i   (clr_filt),
        .rd_idx_i  (rd_idx),
        .rd_word_o (filt_word),
        .present_o (filt_present)
    );

    operand_buffer u_data_buf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (data_wr),
        .clear_i   (clr_data),
        .rd_idx_i  (rd_idx),
        .rd_word_o (data_word),
        .present_o (data_present)
    );

    assign rd_idx     = walk_q[`CONV_IDX_W-1:0];
    assign walk_end   = walk_q[`CONV_IDX_W]; // walked past entry 15
    assign pair_ready = !walk_end && filt_present[rd_idx] && data_present[rd_idx];

    always_ff @(posedge clk_i) begin
        if (rst_i || flush) begin
            acc_q  <= '0;
            walk_q <= '0;
        end else if (enable_i && pair_ready) begin
            acc_q  <= acc_q + filt_word * data_word; // wraps mod 2^32
            walk_q <= walk_q + 1'b1;
        end
    end

    assign status_o = '{acc: acc_q, busy: pair_ready, flush: flush};

    a_walk_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        walk_q <= WALK_W'(`CONV_DEPTH));

endmodule

//--- hdl/conv_writeback.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module conv_writeback (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  conv_accel_pkg::conv_status_t  status_i,
    input  logic                          run_i,
    output logic [`CONV_WORD_W-1:0]       result_o,
    output logic                          result_valid_o,
    output logic                          stall_o
);
    logic                    pending_q;  // run waiting for the accumulator
    logic                    valid_q;
    logic [`CONV_WORD_W-1:0] result_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
            valid_q   <= 1'b0;
            result_q  <= '0;
        end else begin
            valid_q <= 1'b0;
            if (status_i.flush) begin
                pending_q <= 1'b0; // cancelled, no result
            end else if (run_i || pending_q) begin
                if (!status_i.busy) begin
                    valid_q   <= 1'b1;
                    result_q  <= status_i.acc;
                    pending_q <= 1'b0;
                end else begin
                    pending_q <= 1'b1;
                end
            end
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = valid_q;
    assign stall_o        = pending_q; // level, high while the run waits

    a_valid_xor_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        !(result_valid_o && stall_o));

endmodule

//--- hdl/conv_accel_top.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module conv_accel_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     enable_i,
    input  logic                     instr_valid_i,
    input  logic [31:0]              instr_i,
    input  logic [`CONV_WORD_W-1:0]  rs1_i,
    input  logic [`CONV_WORD_W-1:0]  rs2_i,
    output logic [`CONV_WORD_W-1:0]  result_o,
    output logic                     result_valid_o,
    output logic                     stall_o
);
    import conv_accel_pkg::*;

    conv_cmd_t    cmd;
    conv_status_t status;
    logic         run;

    // instruction decode, one cycle
    conv_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .enable_i      (enable_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .cmd_o         (cmd)
    );

    // buffers and multiply-accumulate
    conv_mac u_mac (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .enable_i (enable_i),
        .cmd_i    (cmd),
        .status_o (status),
        .run_o    (run)
    );

    conv_writeback u_writeback (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .status_i       (status),
        .run_i          (run),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .stall_o        (stall_o)
    );

endmodule

//--- verification/conv_accel_checker.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module conv_accel_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        enable_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    input  logic [31:0] result_i,
    input  logic        result_valid_i,
    input  logic        stall_i,
    output int          errors_o,
    output int          pulses_o,
    output logic        waiting_o
);
    localparam logic [4:0] FULL = 5'(`CONV_DEPTH);

    logic [31:0] filt_mem [`CONV_DEPTH];
    logic [31:0] data_mem [`CONV_DEPTH];
    logic [4:0]  filt_fill;
    logic [4:0]  data_fill;
    logic [4:0]  walk;              // next index to be multiplied
    logic [31:0] acc;
    logic        cmd_live;          // command stage, one cycle after the instruction
    logic [2:0]  cmd_f3;
    logic        cmd_pair;
    logic [31:0] cmd_w0;
    logic [31:0] cmd_w1;
    logic        pending;           // run waiting, this is the expected stall level
    logic        exp_valid;
    logic [31:0] exp_result;
    logic        armed = 1'b0;
    int          errors = 0;
    int          pulses = 0;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    // words past entry 15 are lost
    task automatic push_word(input logic to_filt, input logic [31:0] w);
        if (to_filt && filt_fill < FULL) begin
            filt_mem[filt_fill[3:0]] = w;
            filt_fill = filt_fill + 5'd1;
        end else if (!to_filt && data_fill < FULL) begin
            data_mem[data_fill[3:0]] = w;
            data_fill = data_fill + 5'd1;
        end
    endtask

    always @(posedge clk_i) begin
        logic busy;
        logic to_filt;
        if (rst_i) begin
            filt_fill  = '0;
            data_fill  = '0;
            walk       = '0;
            acc        = '0;
            cmd_live   = 1'b0;
            cmd_pair   = 1'b0;
            pending    = 1'b0;
            exp_valid  = 1'b0;
            exp_result = '0;
            armed      = 1'b1;
        end else if (armed) begin
            if (result_valid_i)
                pulses++;
            if (result_valid_i !== exp_valid) begin
                if (exp_valid)
                    $display("%0t: result pulse missing where a run result was due", $time);
                else
                    $display("%0t: result pulse appeared with no run waiting", $time);
                errors++;
            end
            if (stall_i !== pending)
                report_mismatch("stall_o", 32'(pending), 32'(stall_i));
            if (result_i !== exp_result)
                report_mismatch("result_o", exp_result, result_i);

            busy = (walk < filt_fill) && (walk < data_fill); // fills stop at 16
            exp_valid = 1'b0;
            if (cmd_live && (cmd_f3 == `CONV_F3_CLR_FILT || cmd_f3 == `CONV_F3_CLR_DATA)) begin
                pending = 1'b0;   // the clear cancels a waiting run
                acc     = '0;
                walk    = '0;
            end else begin
                if ((cmd_live && cmd_f3 == `CONV_F3_RUN) || pending) begin
                    if (busy) begin
                        pending = 1'b1;
                    end else begin
                        exp_valid  = 1'b1;
                        exp_result = acc;
                        pending    = 1'b0;
                    end
                end
                if (enable_i && busy) begin
                    acc  = acc + filt_mem[walk[3:0]] * data_mem[walk[3:0]];
                    walk = walk + 5'd1;
                end
            end

            // buffer contents change at the end of the command cycle
            if (cmd_live && (cmd_f3 == `CONV_F3_LD_FILT || cmd_f3 == `CONV_F3_LD_DATA)) begin
                to_filt = (cmd_f3 == `CONV_F3_LD_FILT);
                push_word(to_filt, cmd_w0);
                if (cmd_pair)
                    push_word(to_filt, cmd_w1);
            end
            if (cmd_live && cmd_f3 == `CONV_F3_CLR_FILT)
                filt_fill = '0;
            if (cmd_live && cmd_f3 == `CONV_F3_CLR_DATA)
                data_fill = '0;

            cmd_live = instr_valid_i && enable_i && (instr_i[6:0] == `CONV_OPCODE);
            cmd_f3   = instr_i[14:12];
            cmd_pair = instr_i[25 + `CONV_F7_PAIR];
            cmd_w0   = rs1_i;
            cmd_w1   = rs2_i;
        end
    end

    assign errors_o  = errors;
    assign pulses_o  = pulses;
    assign waiting_o = pending;

endmodule

//--- verification/conv_accel_tb.sv
`timescale 1ns/1ps
`include "conv_accel_consts.svh"

module conv_accel_tb;
    logic        clk_i;
    logic        rst_i;
    logic        enable_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] rs1_i;
    logic [31:0] rs2_i;
    logic [31:0] result_o;
    logic        result_valid_o;
    logic        stall_o;
    int          issued = 0;        // instructions sent so far
    int          cycle_count = 0;
    int          errors;
    int          pulses;
    logic        waiting;

    conv_accel_top u_conv_accel_top (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .enable_i       (enable_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .stall_o        (stall_o)
    );

    conv_accel_checker u_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .enable_i       (enable_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .result_i       (result_o),
        .result_valid_i (result_valid_o),
        .stall_i        (stall_o),
        .errors_o       (errors),
        .pulses_o       (pulses),
        .waiting_o      (waiting)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // R-type word, register numbers and spare funct7 bits random
    function automatic logic [31:0] encode(input logic [2:0] f3, input logic pair,
                                           input logic [6:0] opc);
        logic [31:0] w;
        w = $urandom;
        w[6:0] = opc;
        w[14:12] = f3;
        w[25 + `CONV_F7_PAIR] = pair;
        return w;
    endfunction

    function automatic logic [6:0] foreign_opcode();
        logic [6:0] opc;
        opc = 7'($urandom);
        if (opc == `CONV_OPCODE)
            opc = ~opc;
        return opc;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
            instr_i       <= $urandom;  // junk while not valid
        end
    endtask

    // stall is sampled mid-cycle so it reflects the running cycle
    task automatic hold_while_stalled();
        @(negedge clk_i);
        while (stall_o) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
            @(negedge clk_i);
        end
    endtask

    task automatic send(input logic [2:0] f3, input logic pair, input logic [6:0] opc);
        hold_while_stalled();
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= encode(f3, pair, opc);
        rs1_i         <= $urandom;
        rs2_i         <= $urandom;
        issued++;
    endtask

    task automatic load(input logic to_filt, input logic pair);
        send(to_filt ? `CONV_F3_LD_FILT : `CONV_F3_LD_DATA, pair, `CONV_OPCODE);
    endtask

    task automatic clear_both();
        send(`CONV_F3_CLR_FILT, 1'b0, `CONV_OPCODE);
        send(`CONV_F3_CLR_DATA, 1'b0, `CONV_OPCODE);
    endtask

    // stall shows up two cycles after the run, so hold off until then
    task automatic run_now();
        send(`CONV_F3_RUN, 1'b0, `CONV_OPCODE);
        idle(2);
    endtask

    task automatic run_then_clear();
        send(`CONV_F3_RUN, 1'b0, `CONV_OPCODE);
        send(1'($urandom % 2) ? `CONV_F3_CLR_FILT : `CONV_F3_CLR_DATA, 1'b0, `CONV_OPCODE);
        idle(1);
    endtask

    initial begin
        while (cycle_count < 40 * issued + 100) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int pick;
        int end_errors;
        void'($urandom(94));
        rst_i = 1'b1;
        enable_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        rs1_i = '0;
        rs2_i = '0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        idle(5);                        // nothing may come out before a run

        repeat (12) begin
            clear_both();
            repeat (1 + $urandom % 10) begin
                load(1'($urandom % 2), 1'($urandom % 2));
                idle($urandom % 3);
            end
            run_now();
        end

        // run right behind the last pair so the walk lags
        repeat (4) begin
            clear_both();
            load(1'b0, 1'b1);
            idle(3);
            load(1'b1, 1'b1);
            run_now();
        end

        repeat (4) begin
            load(1'b0, 1'b1);
            idle(3);
            load(1'b1, 1'b1);
            run_then_clear();
            load(1'($urandom % 2), 1'b1);
            run_now();
        end

        // overflow and uneven fill
        clear_both();
        repeat (12) load(1'b1, 1'b1);
        repeat (5) load(1'b0, 1'b0);
        run_now();
        repeat (10) load(1'b0, 1'b1);
        run_now();

        // walk frozen by enable while a run waits, stall must hold
        clear_both();
        load(1'b0, 1'b1);
        idle(3);
        load(1'b1, 1'b1);
        send(`CONV_F3_RUN, 1'b0, `CONV_OPCODE);
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        enable_i      <= 1'b0;
        idle(6);
        enable_i <= 1'b1;

        repeat (10) send(3'($urandom), 1'($urandom % 2), foreign_opcode());
        repeat (6) send(3'(5 + $urandom % 3), 1'b0, `CONV_OPCODE);
        run_now();
        hold_while_stalled();
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        enable_i      <= 1'b0;
        repeat (8) send(3'($urandom % 5), 1'($urandom % 2), `CONV_OPCODE);
        idle(1);
        enable_i <= 1'b1;
        run_now();

        repeat (200) begin
            pick = $urandom % 16;
            if (pick < 10)
                load(1'($urandom % 2), 1'($urandom % 2));
            else if (pick == 10)
                send(`CONV_F3_CLR_FILT, 1'b0, `CONV_OPCODE);
            else if (pick == 11)
                send(`CONV_F3_CLR_DATA, 1'b0, `CONV_OPCODE);
            else if (pick < 14)
                run_now();
            else if (pick == 14)
                run_then_clear();
            else
                send(3'($urandom), 1'($urandom % 2), foreign_opcode());
            idle($urandom % 3);
        end

        run_now();
        hold_while_stalled();
        idle(2);
        @(negedge clk_i);
        end_errors = errors;
        if (waiting) begin
            $display("a run was still waiting for its result when the test ended");
            end_errors++;
        end
        $display("instructions: %0d, result pulses: %0d, errors: %0d",
                 issued, pulses, end_errors);
        if (end_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- conv_accel_top.f
+incdir+hdl
hdl/conv_accel_pkg.sv
hdl/conv_decoder.sv
hdl/operand_buffer.sv
hdl/conv_mac.sv
hdl/conv_writeback.sv
hdl/conv_accel_top.sv
verification/conv_accel_checker.sv
verification/conv_accel_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := conv_accel_tb
FILELIST  := conv_accel_top.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
